/* source/charlie_settings.svh */
//************************************************
// build-time sizes for the charlieplexed display
// pins * (pins - 1) has to equal the pixel count
//************************************************
`ifndef CHARLIE_SETTINGS_SVH
`define CHARLIE_SETTINGS_SVH

// one LED per ordered pin pair
`define CHARLIE_PIXELS 12
`define CHARLIE_PINS   4

// wide enough for 0 .. pixels-1
`define CHARLIE_IDX_W  4

// wishbone data and word address
`define CHARLIE_WB_DW  16
`define CHARLIE_WB_AW  2

`endif

/* source/charlie_pkg.sv */
//************************************************
// shared types for the charlieplexed display
//************************************************
`include "charlie_settings.svh"

package charlie_pkg;

  // sizes taken from the settings header
  localparam int unsigned PIXELS       = `CHARLIE_PIXELS;
  localparam int unsigned PINS         = `CHARLIE_PINS;
  // LEDs hanging off one column pin
  localparam int unsigned LEDS_PER_COL = PINS - 1;
  localparam int unsigned PIN_SEL_W    = $clog2(PINS);

  // bit n is LED n
  typedef logic [PIXELS-1:0]          frame_t;
  typedef logic [`CHARLIE_IDX_W-1:0]  pixel_idx_t;
  typedef logic [PINS-1:0]            pins_t;
  typedef logic [PIN_SEL_W-1:0]       pin_sel_t;
  typedef logic [`CHARLIE_WB_DW-1:0]  wb_data_t;
  typedef logic [`CHARLIE_WB_AW-1:0]  wb_addr_t;

  // register map, word addresses
  typedef enum logic [`CHARLIE_WB_AW-1:0] {
    REG_CTRL   = 0,
    REG_FRAME  = 1,
    REG_COMMIT = 2,
    REG_STATUS = 3
  } reg_addr_e;

endpackage

/* source/wb_pixel_regs.sv */
//************************************************
// wishbone classic slave for the display registers
// turns bus writes into frame, commit and enable
//************************************************
`timescale 1ns/1ps

module wb_pixel_regs (
  input  logic                  pixelclock,
  input  logic                  arst_n,
  input  logic                  wb_cyc,
  input  logic                  wb_stb,
  input  logic                  wb_we,
  input  charlie_pkg::wb_addr_t wb_adr,
  input  charlie_pkg::wb_data_t wb_dat_w,
  output charlie_pkg::wb_data_t wb_dat_r,
  output logic                  wb_ack,
  input  logic                  commit_pending,
  output logic                  frame_wr,
  output charlie_pkg::frame_t   frame_wdata,
  output logic                  commit_req,
  output logic                  display_en
);
  import charlie_pkg::*;

  reg_addr_e reg_sel;
  logic      access;
  logic      wr_access;
  frame_t    frame_q;
  wb_data_t  rd_data;

  // new request only while ack is low
  // so every access takes two cycles
  assign access    = wb_cyc & wb_stb & ~wb_ack;
  assign wr_access = access & wb_we;
  assign reg_sel   = reg_addr_e'(wb_adr);

  // control state and strobes
  // strobes are high in the ack cycle
  always_ff @(posedge pixelclock or negedge arst_n) begin
    if (!arst_n) begin
      wb_ack     <= 1'b0;
      frame_wr   <= 1'b0;
      commit_req <= 1'b0;
      display_en <= 1'b0;
      frame_q    <= '0;
    end else begin
      wb_ack     <= access;
      frame_wr   <= wr_access && (reg_sel == REG_FRAME);
      // any data value requests the swap
      commit_req <= wr_access && (reg_sel == REG_COMMIT);
      if (wr_access && (reg_sel == REG_CTRL)) begin
        display_en <= wb_dat_w[0];
      end
      // upper data bits are dropped
      if (wr_access && (reg_sel == REG_FRAME)) begin
        frame_q <= frame_t'(wb_dat_w);
      end
    end
  end

  // the copy kept here is what frame_store loads
  assign frame_wdata = frame_q;

  // read mux
  // commit reads 0, status is read only
  always_comb begin
    case (reg_sel)
      REG_CTRL: begin
        rd_data = wb_data_t'(display_en);
      end
      REG_FRAME: begin
        rd_data = wb_data_t'(frame_q);
      end
      REG_STATUS: begin
        rd_data = wb_data_t'(commit_pending);
      end
      default: begin
        rd_data = '0;
      end
    endcase
  end

  // read data captured on the request edge
  // and held while ack is high
  // status therefore reflects pending as seen at that edge
  always_ff @(posedge pixelclock) begin
    if (access && !wb_we) begin
      wb_dat_r <= rd_data;
    end
  end

endmodule

/* source/frame_store.sv */
//************************************************
// double-buffered frame, shadow takes bus writes
// active is swapped in only at the frame boundary
//************************************************
`timescale 1ns/1ps

module frame_store (
  input  logic                pixelclock,
  input  logic                arst_n,
  input  logic                frame_wr,
  input  charlie_pkg::frame_t frame_wdata,
  input  logic                commit_req,
  input  logic                frame_end,
  output charlie_pkg::frame_t active_frame,
  output logic                commit_pending
);
  import charlie_pkg::*;

  frame_t shadow_q;

  // shadow frame
  // no back-pressure, later writes just replace it
  always_ff @(posedge pixelclock or negedge arst_n) begin
    if (!arst_n) begin
      shadow_q <= '0;
    end else if (frame_wr) begin
      shadow_q <= frame_wdata;
    end
  end

  // active frame
  // only the registered pending flag allows a swap,
  // so a commit arriving with frame_end waits one frame
  always_ff @(posedge pixelclock or negedge arst_n) begin
    if (!arst_n) begin
      active_frame <= '0;
    end else if (frame_end && commit_pending) begin
      active_frame <= shadow_q;
    end
  end

  // pending flag
  // a fresh request wins over the clear at the boundary
  always_ff @(posedge pixelclock or negedge arst_n) begin
    if (!arst_n) begin
      commit_pending <= 1'b0;
    end else if (commit_req) begin
      commit_pending <= 1'b1;
    end else if (frame_end) begin
      commit_pending <= 1'b0;
    end
  end

endmodule

/* source/pixel_scanner.sv */
//************************************************
// steps one pixel per clock through the frame
// and picks the bit of the active frame to show
//************************************************
`timescale 1ns/1ps

module pixel_scanner (
  input  logic                    pixelclock,
  input  logic                    arst_n,
  input  logic                    display_en,
  input  charlie_pkg::frame_t     active_frame,
  output logic                    frame_end,
  output charlie_pkg::pixel_idx_t pixel_index,
  output logic                    pixel_on
);
  import charlie_pkg::*;

  // last index of a frame
  localparam pixel_idx_t LAST_IDX = pixel_idx_t'(PIXELS - 1);

  // free-running index, fixed frame length
  // scanning continues with the display disabled
  always_ff @(posedge pixelclock or negedge arst_n) begin
    if (!arst_n) begin
      pixel_index <= '0;
    end else if (frame_end) begin
      pixel_index <= '0;
    end else begin
      pixel_index <= pixel_index + 1'b1;
    end
  end

  // boundary flag
  // the frame store swaps on this edge
  assign frame_end = (pixel_index == LAST_IDX);

  // current LED
  // the enable blanks without stopping the index
  assign pixel_on = display_en & active_frame[pixel_index];

endmodule

/* source/charlieplexer.sv */
//************************************************
// LED index to pin drive for the charlieplex matrix
// resistors on the diagonal, one LED lit at a time
//************************************************
`timescale 1ns/1ps

module charlieplexer (
  input  charlie_pkg::pixel_idx_t pixel_index,
  input  logic                    pixel_on,
  output charlie_pkg::pins_t      out_en,
  output charlie_pkg::pins_t      out_value
);
  import charlie_pkg::*;

  pixel_idx_t col_full;
  pixel_idx_t rem;
  pixel_idx_t row_full;
  pin_sel_t   col;
  pin_sel_t   row;
  logic       lit;

  // column from the index, LEDS_PER_COL LEDs per column
  assign col_full = pixel_index / pixel_idx_t'(LEDS_PER_COL);
  assign rem      = pixel_index % pixel_idx_t'(LEDS_PER_COL);

  // row skips the diagonal, x == y is the resistor
  assign row_full = (rem >= col_full) ? rem + 1'b1 : rem;

  assign col = pin_sel_t'(col_full);
  assign row = pin_sel_t'(row_full);

  // indexes past the last LED never light anything
  assign lit = pixel_on && (pixel_index < pixel_idx_t'(PIXELS));

  // anode pin high, cathode pin low
  // all other pins float
  always_comb begin
    out_en    = '0;
    out_value = '0;
    if (lit) begin
      out_en[col]    = 1'b1;
      out_en[row]    = 1'b1;
      out_value[col] = 1'b1;
    end
  end

endmodule

/* source/charlie_display_top.sv */
//************************************************
// charlieplexed LED display with a wishbone port
// pins go to tristate pads on the board top
//************************************************
`timescale 1ns/1ps

module charlie_display_top (
  input  logic                  pixelclock,
  input  logic                  arst_n,
  input  logic                  wb_cyc,
  input  logic                  wb_stb,
  input  logic                  wb_we,
  input  charlie_pkg::wb_addr_t wb_adr,
  input  charlie_pkg::wb_data_t wb_dat_w,
  output charlie_pkg::wb_data_t wb_dat_r,
  output logic                  wb_ack,
  output charlie_pkg::pins_t    out_en,
  output charlie_pkg::pins_t    out_value
);
  import charlie_pkg::*;

  // register block to frame store
  logic       frame_wr;
  frame_t     frame_wdata;
  logic       commit_req;
  logic       commit_pending;
  logic       display_en;
  // frame store and scanner
  logic       frame_end;
  frame_t     active_frame;
  // scanner to decoder
  pixel_idx_t pixel_index;
  logic       pixel_on;

  // producer
  wb_pixel_regs u_regs (
    .pixelclock     (pixelclock),
    .arst_n         (arst_n),
    .wb_cyc         (wb_cyc),
    .wb_stb         (wb_stb),
    .wb_we          (wb_we),
    .wb_adr         (wb_adr),
    .wb_dat_w       (wb_dat_w),
    .wb_dat_r       (wb_dat_r),
    .wb_ack         (wb_ack),
    .commit_pending (commit_pending),
    .frame_wr       (frame_wr),
    .frame_wdata    (frame_wdata),
    .commit_req     (commit_req),
    .display_en     (display_en)
  );

  // buffer
  frame_store u_store (
    .pixelclock     (pixelclock),
    .arst_n         (arst_n),
    .frame_wr       (frame_wr),
    .frame_wdata    (frame_wdata),
    .commit_req     (commit_req),
    .frame_end      (frame_end),
    .active_frame   (active_frame),
    .commit_pending (commit_pending)
  );

  // consumer, scanner then pin decoder
  pixel_scanner u_scanner (
    .pixelclock   (pixelclock),
    .arst_n       (arst_n),
    .display_en   (display_en),
    .active_frame (active_frame),
    .frame_end    (frame_end),
    .pixel_index  (pixel_index),
    .pixel_on     (pixel_on)
  );

  charlieplexer u_plexer (
    .pixel_index (pixel_index),
    .pixel_on    (pixel_on),
    .out_en      (out_en),
    .out_value   (out_value)
  );

endmodule

/* verif/charlie_asserts.sv */
//************************************************
// pin and bus rules, bound into the display top
//************************************************
`timescale 1ns/1ps

module charlie_asserts (
  input logic               pixelclock,
  input logic               arst_n,
  input logic               wb_ack,
  input logic               display_en,
  input charlie_pkg::pins_t out_en,
  input charlie_pkg::pins_t out_value
);

  int fail_count = 0;

  // one anode high, one cathode low at most
  a_one_led: assert property (@(posedge pixelclock) disable iff (!arst_n)
    $onehot0(out_value) && $onehot0(out_en & ~out_value))
    else begin
      $error("more than one LED driven");
      fail_count = fail_count + 1;
    end

  // single-cycle ack
  a_ack_pulse: assert property (@(posedge pixelclock) disable iff (!arst_n)
    wb_ack |=> !wb_ack)
    else begin
      $error("ack held for two cycles");
      fail_count = fail_count + 1;
    end

  // blanked while disabled
  a_blank: assert property (@(posedge pixelclock) disable iff (!arst_n)
    !display_en |-> out_en == '0)
    else begin
      $error("pins driven with the display disabled");
      fail_count = fail_count + 1;
    end

endmodule

bind charlie_display_top charlie_asserts u_asserts (
  .pixelclock (pixelclock),
  .arst_n     (arst_n),
  .wb_ack     (wb_ack),
  .display_en (display_en),
  .out_en     (out_en),
  .out_value  (out_value)
);

/* verif/tb_clock.sv */
//************************************************
// testbench pixelclock, 10 ns, and reset
//************************************************
`timescale 1ns/1ps

module tb_clock (
  output logic pixelclock,
  output logic arst_n
);

  // free-running clock
  initial begin
    pixelclock = 1'b0;
    forever #5 pixelclock = ~pixelclock;
  end

  // reset held over 8 rising edges, released mid-cycle
  initial begin
    arst_n = 1'b0;
    repeat (8) @(posedge pixelclock);
    @(negedge pixelclock);
    arst_n = 1'b1;
  end

endmodule

/* verif/display_checker.sv */
//************************************************
// reference model of registers, frames and pins
// compares ack, read data and pin drive every cycle
//************************************************
`timescale 1ns/1ps
`include "charlie_settings.svh"

module display_checker (
  input  logic                  pixelclock,
  input  logic                  arst_n,
  input  logic                  wb_cyc,
  input  logic                  wb_stb,
  input  logic                  wb_we,
  input  charlie_pkg::wb_addr_t wb_adr,
  input  charlie_pkg::wb_data_t wb_dat_w,
  input  charlie_pkg::wb_data_t wb_dat_r,
  input  logic                  wb_ack,
  input  charlie_pkg::pins_t    out_en,
  input  charlie_pkg::pins_t    out_value,
  output int                    error_count,
  output charlie_pkg::frame_t   seen_frame
);
  import charlie_pkg::*;

  localparam pixel_idx_t LAST = pixel_idx_t'(`CHARLIE_PIXELS - 1);

  pixel_idx_t m_idx;
  frame_t     m_shadow;
  frame_t     m_active;
  frame_t     m_regframe;
  logic       m_pending;
  logic       m_en;
  logic       m_ack;
  wb_data_t   exp_rd;
  frame_t     cur;
  logic       req;
  logic       ack_wr;
  int         errs = 0;

  // request cycle, and the acknowledged write edge
  assign req    = wb_cyc & wb_stb & ~m_ack;
  assign ack_wr = wb_cyc & wb_stb & m_ack & wb_we;
  assign error_count = errs;

  // model steps on every edge after reset release
  always_ff @(posedge pixelclock or negedge arst_n) begin
    if (!arst_n) begin
      m_idx      <= '0;
      m_shadow   <= '0;
      m_active   <= '0;
      m_regframe <= '0;
      m_pending  <= 1'b0;
      m_en       <= 1'b0;
      m_ack      <= 1'b0;
      exp_rd     <= '0;
    end else begin
      // ack one edge after a request, one cycle long
      m_ack <= req;
      // fixed 12-cycle frame
      m_idx <= (m_idx == LAST) ? '0 : m_idx + 4'd1;
      // swap only at the boundary, with the old shadow
      if (m_idx == LAST && m_pending) begin
        m_active <= m_shadow;
      end
      // commit on the same boundary waits a frame
      if (ack_wr && wb_adr == REG_COMMIT) begin
        m_pending <= 1'b1;
      end else if (m_idx == LAST) begin
        m_pending <= 1'b0;
      end
      if (ack_wr && wb_adr == REG_FRAME) begin
        m_shadow <= wb_dat_w[`CHARLIE_PIXELS-1:0];
      end
      // register copies follow the request edge
      if (req && wb_we && wb_adr == REG_CTRL) begin
        m_en <= wb_dat_w[0];
      end
      if (req && wb_we && wb_adr == REG_FRAME) begin
        m_regframe <= wb_dat_w[`CHARLIE_PIXELS-1:0];
      end
      // read value as seen at the request edge
      if (req && !wb_we) begin
        case (wb_adr)
          REG_CTRL:   exp_rd <= wb_data_t'(m_en);
          REG_FRAME:  exp_rd <= wb_data_t'(m_regframe);
          REG_STATUS: exp_rd <= wb_data_t'(m_pending);
          default:    exp_rd <= '0;
        endcase
      end
    end
  end

  // compare mid-cycle where everything is settled
  always @(negedge pixelclock) begin
    logic [1:0] col;
    logic [1:0] rem;
    logic [1:0] row;
    pins_t      exp_en;
    pins_t      exp_val;
    frame_t     cur_next;
    if (arst_n) begin
      // column n/3, row skips the diagonal
      col = 2'(m_idx / 4'd3);
      rem = 2'(m_idx % 4'd3);
      row = (rem >= col) ? rem + 2'd1 : rem;
      exp_en  = '0;
      exp_val = '0;
      if (m_en && m_active[m_idx]) begin
        exp_en[col]  = 1'b1;
        exp_en[row]  = 1'b1;
        exp_val[col] = 1'b1;
      end
      if (out_en !== exp_en) begin
        $display("ERROR %0t out_en expected %b got %b", $time, exp_en, out_en);
        errs = errs + 1;
      end
      if (out_value !== exp_val) begin
        $display("ERROR %0t out_value expected %b got %b", $time, exp_val, out_value);
        errs = errs + 1;
      end
      if (wb_ack !== m_ack) begin
        $display("ERROR %0t wb_ack expected %b got %b", $time, m_ack, wb_ack);
        errs = errs + 1;
      end
      if (wb_cyc && wb_ack && !wb_we && wb_dat_r !== exp_rd) begin
        $display("ERROR %0t wb_dat_r expected %h got %h", $time, exp_rd, wb_dat_r);
        errs = errs + 1;
      end
      // rebuild the scanned image pixel by pixel
      cur_next = cur;
      cur_next[m_idx] = |out_en;
      cur <= cur_next;
      if (m_idx == LAST) begin
        seen_frame <= cur_next;
      end
    end else begin
      cur        <= '0;
      seen_frame <= '0;
    end
  end

endmodule

/* verif/tb_top.sv */
//************************************************
// testbench top, runs the golden bus sequence
// closing line and verdict are printed here
//************************************************
`timescale 1ns/1ps

module tb_top;
  import charlie_pkg::*;

  logic       pixelclock;
  logic       arst_n;
  logic       wb_cyc;
  logic       wb_stb;
  logic       wb_we;
  wb_addr_t   wb_adr;
  wb_data_t   wb_dat_w;
  wb_data_t   wb_dat_r;
  logic       wb_ack;
  pins_t      out_en;
  pins_t      out_value;
  int         chk_errors;
  frame_t     seen_frame;
  // op, addr, data, expect per entry
  logic [39:0] golden [0:63];
  logic [31:0] lfsr;
  int          line_count;
  bit          loaded = 1'b0;
  int          tb_errors = 0;

  tb_clock u_clk (
    .pixelclock (pixelclock),
    .arst_n     (arst_n)
  );

  charlie_display_top u_dut (
    .pixelclock (pixelclock),
    .arst_n     (arst_n),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_we      (wb_we),
    .wb_adr     (wb_adr),
    .wb_dat_w   (wb_dat_w),
    .wb_dat_r   (wb_dat_r),
    .wb_ack     (wb_ack),
    .out_en     (out_en),
    .out_value  (out_value)
  );

  display_checker u_chk (
    .pixelclock  (pixelclock),
    .arst_n      (arst_n),
    .wb_cyc      (wb_cyc),
    .wb_stb      (wb_stb),
    .wb_we       (wb_we),
    .wb_adr      (wb_adr),
    .wb_dat_w    (wb_dat_w),
    .wb_dat_r    (wb_dat_r),
    .wb_ack      (wb_ack),
    .out_en      (out_en),
    .out_value   (out_value),
    .error_count (chk_errors),
    .seen_frame  (seen_frame)
  );

  // galois shift, one step per random bit
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  // idle cycles before a write, 0 to 7
  task automatic random_gap();
    logic [2:0] gap;
    for (int b = 0; b < 3; b++) begin
      gap[b] = lfsr[0];
      lfsr   = lfsr_next(lfsr);
    end
    repeat (gap) begin
      @(posedge pixelclock);
      #1;
    end
  endtask

  // one classic cycle, entered and left 1 ns after an edge
  task automatic bus_access(input logic we, input wb_addr_t adr, input wb_data_t dat,
                            output wb_data_t rd);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = dat;
    @(negedge pixelclock);
    while (!wb_ack) @(negedge pixelclock);
    rd = wb_dat_r;
    @(posedge pixelclock);
    #1;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  // long enough for a swap plus one whole frame
  task automatic check_display(input frame_t exp);
    repeat (28) @(posedge pixelclock);
    #1;
    if (seen_frame !== exp) begin
      $display("ERROR %0t seen_frame expected %h got %h", $time, exp, seen_frame);
      tb_errors = tb_errors + 1;
    end
  endtask

  initial begin
    logic [39:0] g;
    wb_data_t    rd;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_w = '0;
    lfsr     = 32'h56e91783;
    $readmemh("verif/display_golden.txt", golden);
    line_count = 0;
    while (line_count < 63 && golden[line_count][39:36] != 4'hf) begin
      line_count = line_count + 1;
    end
    loaded = 1'b1;
    wait (arst_n);
    @(posedge pixelclock);
    #1;
    for (int i = 0; i < line_count; i++) begin
      g = golden[i];
      case (g[39:36])
        4'h1: begin
          random_gap();
          bus_access(1'b1, g[33:32], g[31:16], rd);
        end
        4'h2: begin
          // no gap, status right after a commit is deterministic
          bus_access(1'b0, g[33:32], '0, rd);
          if (rd !== g[15:0]) begin
            $display("ERROR %0t wb_dat_r adr %0d expected %h got %h",
                     $time, g[33:32], g[15:0], rd);
            tb_errors = tb_errors + 1;
          end
        end
        4'h3: begin
          repeat (g[31:16]) @(posedge pixelclock);
          #1;
        end
        4'h4: check_display(g[11:0]);
        4'h5: begin
          random_gap();
          bus_access(1'b1, REG_FRAME, g[31:16], rd);
          random_gap();
          bus_access(1'b1, REG_COMMIT, '0, rd);
          check_display(g[11:0]);
        end
        default: begin
          $display("golden line %0d holds an unknown operation", i);
          tb_errors = tb_errors + 1;
        end
      endcase
    end
    $display("errors: checker %0d, golden %0d, assertions %0d",
             chk_errors, tb_errors, u_dut.u_asserts.fail_count);
    if (chk_errors + tb_errors + u_dut.u_asserts.fail_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  // watchdog, 200 cycles per golden line
  initial begin
    wait (loaded);
    repeat ((line_count + 1) * 200) @(posedge pixelclock);
    $display("simulation timed out before the golden sequence ended");
    $display("Checks failed");
    $finish;
  end

endmodule

/* verif/display_golden.txt */
// columns op_adr_data_expect: op 1 write, 2 read, 3 idle data cycles,
// 4 check scanned frame, 5 write frame + commit + check, f end
3_0_0018_0000 // reset state over two frames
4_0_0000_0000
2_0_0000_0000
2_3_0000_0000
1_1_0a5c_0000
2_1_0000_0a5c
1_0_0001_0000
2_0_0000_0001
4_0_0000_0000 // enabled, nothing committed yet
1_2_0000_0000
2_3_0000_0001
3_0_000e_0000
2_3_0000_0000
4_0_0000_0a5c
1_1_0123_0000 // two writes, no commit
1_1_03f0_0000
4_0_0000_0a5c
2_1_0000_03f0
2_2_0000_0000
1_2_0000_0000
4_0_0000_03f0
1_3_ffff_0000
2_3_0000_0000
1_0_0000_0000 // blank and resume
4_0_0000_0000
1_0_0001_0000
4_0_0000_03f0
5_0_0001_0001 // each LED alone
5_0_0002_0002
5_0_0004_0004
5_0_0008_0008
5_0_0010_0010
5_0_0020_0020
5_0_0040_0040
5_0_0080_0080
5_0_0100_0100
5_0_0200_0200
5_0_0400_0400
5_0_0800_0800
f_0_0000_0000

/* filelist.f */
+incdir+source
source/charlie_pkg.sv
source/wb_pixel_regs.sv
source/frame_store.sv
source/pixel_scanner.sv
source/charlieplexer.sv
source/charlie_display_top.sv
verif/charlie_asserts.sv
verif/tb_clock.sv
verif/display_checker.sv
verif/tb_top.sv

/* Makefile */
# Verilator build and run of the display testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check the log"
	@echo "  clean  remove build output and log"

test:
	verilator --binary --timing --assert -f filelist.f --top-module tb_top -Mdir obj_dir
	./obj_dir/Vtb_top | tee $(LOG)
	@if grep -q "Checks failed" $(LOG); then echo "test FAILED"; exit 1; fi
	@if ! grep -q "All checks passed" $(LOG); then echo "test FAILED"; exit 1; fi
	@echo "test PASSED"

clean:
	rm -rf obj_dir $(LOG)
